//--- source/lane_config_pkg.sv
// lane geometry and unit latencies, referenced by scoped name from RTL and testbench
`default_nettype none

package lane_config_pkg;

  // element width of one lane
  localparam int XLEN = 32;

  // lanes in the slice, all driven by one issue strobe
  localparam int LANES = 4;

  // issue to lane result, in cycles
  localparam int MUL_LATENCY = 3;   // two pipe stages + result register
  localparam int DIV_LATENCY = 33;  // 32 iterations + result register

  // the divider runs one restoring step per bit
  localparam int DIV_ITERATIONS = DIV_LATENCY - 1;

endpackage

`default_nettype wire

//--- source/vector_types_pkg.sv
// unit selector, per-unit opcode enums and the issue, operand and result structs of a lane
`default_nettype none

package vector_types_pkg;

  // unit selector carried in the issue
  typedef enum logic [2:0] {
    FU_ARITH,
    FU_RED,    // running reduction on the arithmetic unit
    FU_MUL,
    FU_DIV,
    FU_MASK
  } fu_type_t;

  // arithmetic ops, reductions use ADD, MAX and MIN only
  typedef enum logic [3:0] {
    ADD, SUB, AND, OR, XOR,
    SLL, SRL, SRA,
    MIN, MAX, MINU, MAXU
  } arith_op_t;

  typedef enum logic [1:0] {
    MUL,     // low half
    MULH,    // high half, signed x signed
    MULHU,   // high half, unsigned x unsigned
    MULHSU   // high half, signed x unsigned
  } mul_op_t;

  typedef enum logic [1:0] {DIV, DIVU, REM, REMU} div_op_t;

  typedef enum logic [2:0] {MAND, MOR, MXOR, MNAND, MPOPC, MFIRST} mask_op_t;

  // broadcast to every lane
  typedef struct packed {
    logic       valid;      // one-cycle strobe
    fu_type_t   fu;
    logic [3:0] op;         // raw opcode, cast per unit
    logic       red_start;  // restart the accumulator
  } lane_issue_t;

  typedef struct packed {
    logic [lane_config_pkg::XLEN-1:0] a;
    logic [lane_config_pkg::XLEN-1:0] b;
  } lane_operands_t;

  typedef struct packed {
    logic                             valid;
    logic                             exception;  // divide by zero only
    logic [lane_config_pkg::XLEN-1:0] data;
  } lane_result_t;

endpackage

`default_nettype wire

//--- source/arithmetic_unit.sv
// single-cycle integer ALU plus reduction accumulator, result is combinational for the lane
`timescale 1ns/1ps
`default_nettype none

module arithmetic_unit (
  input  logic                              CLK,
  input  logic                              nRST,
  input  logic                              start,
  input  logic                              red,        // reduction, not plain ALU
  input  logic                              red_start,
  input  vector_types_pkg::arith_op_t       op,
  input  logic [lane_config_pkg::XLEN-1:0]  a,
  input  logic [lane_config_pkg::XLEN-1:0]  b,
  output logic [lane_config_pkg::XLEN-1:0]  result
);

  logic [lane_config_pkg::XLEN-1:0]         alu_out;
  logic [lane_config_pkg::XLEN-1:0]         acc;       // running reduction value
  logic [lane_config_pkg::XLEN-1:0]         acc_base;  // acc, or identity on restart
  logic [lane_config_pkg::XLEN-1:0]         red_next;
  logic [$clog2(lane_config_pkg::XLEN)-1:0] shamt;

  assign shamt = b[$clog2(lane_config_pkg::XLEN)-1:0];  // low five bits

  always_comb begin
    case (op)
      vector_types_pkg::ADD:  alu_out = a + b;
      vector_types_pkg::SUB:  alu_out = a - b;
      vector_types_pkg::AND:  alu_out = a & b;
      vector_types_pkg::OR:   alu_out = a | b;
      vector_types_pkg::XOR:  alu_out = a ^ b;
      vector_types_pkg::SLL:  alu_out = a << shamt;
      vector_types_pkg::SRL:  alu_out = a >> shamt;
      vector_types_pkg::SRA:  alu_out = $signed(a) >>> shamt;
      vector_types_pkg::MIN:  alu_out = ($signed(a) < $signed(b)) ? a : b;
      vector_types_pkg::MAX:  alu_out = ($signed(a) > $signed(b)) ? a : b;
      vector_types_pkg::MINU: alu_out = (a < b) ? a : b;
      vector_types_pkg::MAXU: alu_out = (a > b) ? a : b;
      default:                alu_out = '0;
    endcase
  end

  // identity per reduction op on restart
  always_comb begin
    acc_base = acc;
    if (red_start) begin
      case (op)
        vector_types_pkg::MAX: acc_base = {1'b1, {(lane_config_pkg::XLEN-1){1'b0}}};
        vector_types_pkg::MIN: acc_base = {1'b0, {(lane_config_pkg::XLEN-1){1'b1}}};
        default:               acc_base = '0;
      endcase
    end
    case (op)
      vector_types_pkg::MAX: red_next = ($signed(a) > $signed(acc_base)) ? a : acc_base;
      vector_types_pkg::MIN: red_next = ($signed(a) < $signed(acc_base)) ? a : acc_base;
      default:               red_next = acc_base + a;  // ADD
    endcase
  end

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      acc <= '0;
    end else if (start && red) begin
      acc <= red_next;
    end
  end

  assign result = red ? red_next : alu_out;  // reduction reports new acc

endmodule

`default_nettype wire

//--- source/multiply_unit.sv
// two-stage pipelined multiplier, one issue per cycle, low or high half of the product
`timescale 1ns/1ps
`default_nettype none

module multiply_unit (
  input  logic                             CLK,
  input  logic                             nRST,
  input  logic                             start,
  input  vector_types_pkg::mul_op_t        op,
  input  logic [lane_config_pkg::XLEN-1:0] a,
  input  logic [lane_config_pkg::XLEN-1:0] b,
  output logic [lane_config_pkg::XLEN-1:0] result,
  output logic                             done,
  output logic                             next_done
);

  // stage valids, bit 0 is stage one
  logic [lane_config_pkg::MUL_LATENCY-2:0] vld;

  logic signed [lane_config_pkg::XLEN:0]     a_s1;  // 33-bit extended operands
  logic signed [lane_config_pkg::XLEN:0]     b_s1;
  logic                                      hi_s1;
  logic signed [2*lane_config_pkg::XLEN+1:0] full;  // 66-bit signed product
  logic [2*lane_config_pkg::XLEN-1:0]        prod_s2;
  logic                                      hi_s2;
  logic                                      a_sgn;
  logic                                      b_sgn;

  // extension per op
  assign a_sgn = (op == vector_types_pkg::MULH) || (op == vector_types_pkg::MULHSU);
  assign b_sgn = (op == vector_types_pkg::MULH);

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      vld <= '0;
    end else begin
      vld <= {vld[lane_config_pkg::MUL_LATENCY-3:0], start};
    end
  end

  // stage one, operands and select
  always_ff @(posedge CLK) begin
    if (start) begin
      a_s1  <= {a_sgn & a[lane_config_pkg::XLEN-1], a};
      b_s1  <= {b_sgn & b[lane_config_pkg::XLEN-1], b};
      hi_s1 <= (op != vector_types_pkg::MUL);
    end
  end

  assign full = a_s1 * b_s1;

  // stage two, product
  always_ff @(posedge CLK) begin
    if (vld[0]) begin
      prod_s2 <= full[2*lane_config_pkg::XLEN-1:0];  // low 64 bits are exact
      hi_s2   <= hi_s1;
    end
  end

  assign result = hi_s2 ? prod_s2[2*lane_config_pkg::XLEN-1:lane_config_pkg::XLEN]
                        : prod_s2[lane_config_pkg::XLEN-1:0];

  assign done      = vld[lane_config_pkg::MUL_LATENCY-2];
  assign next_done = vld[lane_config_pkg::MUL_LATENCY-3];  // done follows next cycle

endmodule

`default_nettype wire

//--- source/divide_unit.sv
// iterative restoring divider, one quotient bit per cycle, signed and unsigned div and rem
`timescale 1ns/1ps
`default_nettype none

module divide_unit (
  input  logic                             CLK,
  input  logic                             nRST,
  input  logic                             start,
  input  vector_types_pkg::div_op_t        op,
  input  logic [lane_config_pkg::XLEN-1:0] a,
  input  logic [lane_config_pkg::XLEN-1:0] b,
  output logic [lane_config_pkg::XLEN-1:0] result,
  output logic                             done,
  output logic                             busy,
  output logic                             exception
);

  logic                                   sgn_op;
  logic [lane_config_pkg::XLEN-1:0]       mag_a, mag_b;
  logic [lane_config_pkg::XLEN-1:0]       rem_q, quo_q, dvs_q;
  logic [lane_config_pkg::XLEN-1:0]       src_rem, src_quo, src_dvs;
  logic [lane_config_pkg::XLEN-1:0]       step_rem, step_quo;
  logic [lane_config_pkg::XLEN+1:0]       diff;  // top bit is the borrow
  logic [$clog2(lane_config_pkg::XLEN):0] count;
  logic                                   last;
  logic                                   neg_quo, neg_rem, div_zero;
  vector_types_pkg::div_op_t              op_q;

  assign sgn_op = (op == vector_types_pkg::DIV) || (op == vector_types_pkg::REM);
  assign mag_a  = (sgn_op && a[lane_config_pkg::XLEN-1]) ? -a : a;
  assign mag_b  = (sgn_op && b[lane_config_pkg::XLEN-1]) ? -b : b;

  // first step runs on the fresh magnitudes in the start cycle
  assign src_rem = busy ? rem_q : '0;
  assign src_quo = busy ? quo_q : mag_a;
  assign src_dvs = busy ? dvs_q : mag_b;
  assign diff    = {1'b0, src_rem, src_quo[lane_config_pkg::XLEN-1]} - {2'b00, src_dvs};

  always_comb begin
    if (!diff[lane_config_pkg::XLEN+1]) begin  // fits, keep the difference
      step_rem = diff[lane_config_pkg::XLEN-1:0];
      step_quo = {src_quo[lane_config_pkg::XLEN-2:0], 1'b1};
    end else begin  // restore
      step_rem = {src_rem[lane_config_pkg::XLEN-2:0], src_quo[lane_config_pkg::XLEN-1]};
      step_quo = {src_quo[lane_config_pkg::XLEN-2:0], 1'b0};
    end
  end

  assign last = (count == ($clog2(lane_config_pkg::XLEN)+1)'(lane_config_pkg::DIV_ITERATIONS));
  assign done = busy && last;

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      busy  <= 1'b0;
      count <= '0;
    end else if (start) begin
      busy  <= 1'b1;
      count <= 1;  // one step already taken
    end else if (done) begin
      busy  <= 1'b0;
    end else if (busy) begin
      count <= count + 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (start || (busy && !last)) begin
      rem_q <= step_rem;
      quo_q <= step_quo;
    end
    if (start) begin
      dvs_q    <= mag_b;
      op_q     <= op;
      neg_quo  <= sgn_op && (a[lane_config_pkg::XLEN-1] ^ b[lane_config_pkg::XLEN-1]);
      neg_rem  <= sgn_op && a[lane_config_pkg::XLEN-1];  // rem takes dividend sign
      div_zero <= (b == '0);
    end
  end

  // sign fixup, min / -1 falls out as the dividend with no special case
  always_comb begin
    case (op_q)
      vector_types_pkg::DIV,
      vector_types_pkg::DIVU: result = div_zero ? '1 : (neg_quo ? -quo_q : quo_q);
      default:                result = neg_rem ? -rem_q : rem_q;  // rem = dividend on /0
    endcase
  end

  assign exception = done && div_zero;

  // issuer must hold off while a division is running
  a_no_start_busy: assert property (@(posedge CLK) disable iff (!nRST) start |-> !busy)
    else $error("divide_unit: start while busy");

endmodule

`default_nettype wire

//--- source/mask_unit.sv
// combinational mask logic, population count and find-first-set of one lane
`timescale 1ns/1ps
`default_nettype none

module mask_unit (
  input  vector_types_pkg::mask_op_t       op,
  input  logic [lane_config_pkg::XLEN-1:0] a,
  input  logic [lane_config_pkg::XLEN-1:0] b,
  output logic [lane_config_pkg::XLEN-1:0] result
);

  logic [$clog2(lane_config_pkg::XLEN):0] pop;    // 0..32 needs six bits
  logic [lane_config_pkg::XLEN-1:0]       first;  // index of lowest set bit

  always_comb begin
    pop   = '0;
    first = '1;  // no bit set
    // scan down so the lowest set bit wins
    for (int i = lane_config_pkg::XLEN - 1; i >= 0; i--) begin
      pop = pop + ($clog2(lane_config_pkg::XLEN)+1)'(a[i]);
      if (a[i]) begin
        first = lane_config_pkg::XLEN'(i);
      end
    end
  end

  always_comb begin
    case (op)
      vector_types_pkg::MAND:   result = a & b;
      vector_types_pkg::MOR:    result = a | b;
      vector_types_pkg::MXOR:   result = a ^ b;
      vector_types_pkg::MNAND:  result = ~(a & b);
      vector_types_pkg::MPOPC:  result = lane_config_pkg::XLEN'(pop);  // zero extend
      vector_types_pkg::MFIRST: result = first;
      default:                  result = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- source/vector_lane.sv
// one vector lane, issue decode into unit starts, busy tracking and the registered result
`timescale 1ns/1ps
`default_nettype none

module vector_lane (
  input  logic                            CLK,
  input  logic                            nRST,
  input  vector_types_pkg::lane_issue_t   issue,
  input  vector_types_pkg::lane_operands_t operands,
  output vector_types_pkg::lane_result_t  result,
  output logic                            busy,
  output logic                            next_busy
);

  logic start_arith, start_mul, start_div, red, is_mask, single_done;
  logic mul_done, mul_next_done;
  logic div_done, div_busy, div_exc;
  logic div_tail;  // div result sits in the output register
  logic valid_q, exc_q;
  logic [lane_config_pkg::XLEN-1:0] arith_data, mul_data, div_data, mask_data;
  logic [lane_config_pkg::XLEN-1:0] sel_data, data_q;

  // decode, each start is the strobe qualified by the unit selector
  assign red         = (issue.fu == vector_types_pkg::FU_RED);
  assign is_mask     = (issue.fu == vector_types_pkg::FU_MASK);
  assign start_arith = issue.valid && ((issue.fu == vector_types_pkg::FU_ARITH) || red);
  assign start_mul   = issue.valid && (issue.fu == vector_types_pkg::FU_MUL);
  assign start_div   = issue.valid && (issue.fu == vector_types_pkg::FU_DIV);
  assign single_done = start_arith || (issue.valid && is_mask);  // completes this cycle

  arithmetic_unit i_arith (
    .CLK, .nRST,
    .start(start_arith), .red, .red_start(issue.red_start),
    .op(vector_types_pkg::arith_op_t'(issue.op)),
    .a(operands.a), .b(operands.b),
    .result(arith_data)
  );

  multiply_unit i_mul (
    .CLK, .nRST,
    .start(start_mul),
    .op(vector_types_pkg::mul_op_t'(issue.op[1:0])),
    .a(operands.a), .b(operands.b),
    .result(mul_data), .done(mul_done), .next_done(mul_next_done)
  );

  divide_unit i_div (
    .CLK, .nRST,
    .start(start_div),
    .op(vector_types_pkg::div_op_t'(issue.op[1:0])),
    .a(operands.a), .b(operands.b),
    .result(div_data), .done(div_done), .busy(div_busy), .exception(div_exc)
  );

  mask_unit i_mask (
    .op(vector_types_pkg::mask_op_t'(issue.op[2:0])),
    .a(operands.a), .b(operands.b),
    .result(mask_data)
  );

  // at most one source completes per cycle
  always_comb begin
    if (div_done)      sel_data = div_data;
    else if (mul_done) sel_data = mul_data;
    else if (is_mask)  sel_data = mask_data;
    else               sel_data = arith_data;
  end

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      valid_q   <= 1'b0;
      exc_q     <= 1'b0;
      div_tail  <= 1'b0;
      next_busy <= 1'b0;
    end else begin
      valid_q   <= single_done || mul_done || div_done;
      exc_q     <= div_exc;         // only ever high with div_done
      div_tail  <= div_done;
      next_busy <= mul_next_done;   // high while mul done is on the unit output
    end
  end

  always_ff @(posedge CLK) begin
    data_q <= sel_data;
  end

  assign result.valid     = valid_q;
  assign result.exception = exc_q;
  assign result.data      = data_q;
  assign busy             = div_busy || div_tail;  // t+1 through t+33

  // issue rules seen from the lane
  a_next_busy: assert property (@(posedge CLK) disable iff (!nRST)
    (issue.valid && issue.fu != vector_types_pkg::FU_MUL) |-> !next_busy)
    else $error("vector_lane: non-MUL issue while next_busy");
  a_busy: assert property (@(posedge CLK) disable iff (!nRST) issue.valid |-> !busy)
    else $error("vector_lane: issue while busy");
  a_one_done: assert property (@(posedge CLK) disable iff (!nRST)
    $onehot0({single_done, mul_done, div_done}))
    else $error("vector_lane: two completions in one cycle");

endmodule

`default_nettype wire

//--- source/vector_lanes.sv
// slice top, LANES identical lanes in lockstep under one broadcast issue strobe
`timescale 1ns/1ps
`default_nettype none

module vector_lanes (
  input  logic                             CLK,
  input  logic                             nRST,
  input  vector_types_pkg::lane_issue_t    issue,  // same for every lane
  input  vector_types_pkg::lane_operands_t operands [lane_config_pkg::LANES],
  output vector_types_pkg::lane_result_t   results  [lane_config_pkg::LANES],
  output logic [lane_config_pkg::LANES-1:0] busy,
  output logic [lane_config_pkg::LANES-1:0] next_busy
);

  // per-lane operands in, per-lane result out
  for (genvar i = 0; i < lane_config_pkg::LANES; i++) begin : g_lane
    vector_lane i_lane (
      .CLK,
      .nRST,
      .issue,
      .operands  (operands[i]),
      .result    (results[i]),
      .busy      (busy[i]),       // equal across lanes in lockstep
      .next_busy (next_busy[i])
    );
  end

endmodule

`default_nettype wire

//--- bench/vector_lanes_tb.sv
// self-checking testbench for the vector slice, LFSR stimulus checked against a rule-based model
`timescale 1ns/1ps
`default_nettype none

module vector_lanes_tb;

  typedef logic [lane_config_pkg::XLEN-1:0]   word_t;
  typedef logic [2*lane_config_pkg::XLEN-1:0] dword_t;

  // one expected result across all lanes, due at a posedge count
  typedef struct packed {
    int                                                            due;
    logic                                                          mul;  // feeds next_busy model
    logic [lane_config_pkg::LANES-1:0]                             exc;
    logic [lane_config_pkg::LANES-1:0][lane_config_pkg::XLEN-1:0] data;
  } expect_t;

  logic                                    CLK = 1'b0;
  logic                                    nRST;
  vector_types_pkg::lane_issue_t           issue;
  vector_types_pkg::lane_operands_t        operands [lane_config_pkg::LANES];
  vector_types_pkg::lane_result_t          results  [lane_config_pkg::LANES];
  logic [lane_config_pkg::LANES-1:0]       busy;
  logic [lane_config_pkg::LANES-1:0]       next_busy;

  expect_t                                 exp_q [$];  // in issue order
  logic                                    exp_valid = 1'b0;
  logic                                    exp_busy = 1'b0;
  logic                                    exp_next_busy = 1'b0;
  logic [lane_config_pkg::LANES-1:0]       exp_exc = '0;
  logic [lane_config_pkg::LANES-1:0][lane_config_pkg::XLEN-1:0] exp_data = '0;
  word_t                                   stage_a [lane_config_pkg::LANES];
  word_t                                   stage_b [lane_config_pkg::LANES];
  word_t                                   acc [lane_config_pkg::LANES];  // model accumulators
  logic [31:0]                             lfsr = 32'h5c2b;
  int                                      cyc = 0;          // posedges seen so far
  int                                      div_issue = -1000;
  int                                      check_errors = 0;
  int                                      timeout_errors = 0;
  int                                      results_seen = 0;

  vector_lanes i_dut (
    .CLK,
    .nRST,
    .issue,
    .operands,
    .results,
    .busy,
    .next_busy
  );

  always #20 CLK = ~CLK;  // 40 ns period

  always @(posedge CLK) cyc <= cyc + 1;

  // x^32 + x^22 + x^2 + x + 1, one step per bit
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output word_t v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v    = {v[lane_config_pkg::XLEN-2:0], lfsr[31]};
    end
  endtask

  function automatic word_t most_negative();
    return {1'b1, {(lane_config_pkg::XLEN-1){1'b0}}};
  endfunction

  // a quarter of operands are corner values
  task automatic random_operand(output word_t v);
    word_t pick;
    take_bits(2, pick);
    if (pick[1:0] == 2'd0) begin
      take_bits(2, pick);
      case (pick[1:0])
        2'd0:    v = '0;
        2'd1:    v = '1;
        2'd2:    v = most_negative();
        default: v = word_t'(1);
      endcase
    end else begin
      take_bits(lane_config_pkg::XLEN, v);
    end
  endtask

  function automatic word_t arith_model(input logic [3:0] op, input word_t a, input word_t b);
    case (op)
      vector_types_pkg::ADD:  return a + b;
      vector_types_pkg::SUB:  return a - b;
      vector_types_pkg::AND:  return a & b;
      vector_types_pkg::OR:   return a | b;
      vector_types_pkg::XOR:  return a ^ b;
      vector_types_pkg::SLL:  return a << b[4:0];   // low five bits only
      vector_types_pkg::SRL:  return a >> b[4:0];
      vector_types_pkg::SRA:  return word_t'($signed(a) >>> b[4:0]);
      vector_types_pkg::MIN:  return ($signed(a) < $signed(b)) ? a : b;
      vector_types_pkg::MAX:  return ($signed(a) > $signed(b)) ? a : b;
      vector_types_pkg::MINU: return (a < b) ? a : b;
      vector_types_pkg::MAXU: return (a > b) ? a : b;
      default:                return '0;
    endcase
  endfunction

  function automatic word_t reduction_identity(input logic [3:0] op);
    case (op)
      vector_types_pkg::MAX: return most_negative();
      vector_types_pkg::MIN: return ~most_negative();
      default:               return '0;
    endcase
  endfunction

  // 64-bit wraparound products, high half still exact
  function automatic word_t mul_model(input logic [1:0] op, input word_t a, input word_t b);
    dword_t p;
    case (op)
      vector_types_pkg::MULH:   p = dword_t'($signed(a)) * dword_t'($signed(b));
      vector_types_pkg::MULHSU: p = dword_t'($signed(a)) * dword_t'(b);
      default:                  p = dword_t'(a) * dword_t'(b);
    endcase
    if (op == vector_types_pkg::MUL) begin
      return p[lane_config_pkg::XLEN-1:0];
    end
    return p[2*lane_config_pkg::XLEN-1:lane_config_pkg::XLEN];
  endfunction

  task automatic div_model(input logic [1:0] op, input word_t a, input word_t b,
                           output word_t d, output logic exc);
    logic  sgn;
    word_t q;
    word_t r;
    sgn = (op == vector_types_pkg::DIV) || (op == vector_types_pkg::REM);
    exc = (b == '0);
    if (b == '0) begin
      q = '1;  // all ones, rem keeps dividend
      r = a;
    end else if (sgn && a == most_negative() && b == '1) begin
      q = a;   // overflow case
      r = '0;
    end else if (sgn) begin
      q = word_t'($signed(a) / $signed(b));
      r = word_t'($signed(a) % $signed(b));
    end else begin
      q = a / b;
      r = a % b;
    end
    d = (op == vector_types_pkg::DIV || op == vector_types_pkg::DIVU) ? q : r;
  endtask

  function automatic word_t mask_model(input logic [2:0] op, input word_t a, input word_t b);
    int idx;
    idx = 0;
    while (idx < lane_config_pkg::XLEN && !a[idx]) begin
      idx++;
    end
    case (op)
      vector_types_pkg::MAND:   return a & b;
      vector_types_pkg::MOR:    return a | b;
      vector_types_pkg::MXOR:   return a ^ b;
      vector_types_pkg::MNAND:  return ~(a & b);
      vector_types_pkg::MPOPC:  return word_t'($countones(a));
      vector_types_pkg::MFIRST: return (idx == lane_config_pkg::XLEN) ? '1 : word_t'(idx);
      default:                  return '0;
    endcase
  endfunction

  task automatic model_lane(input vector_types_pkg::fu_type_t fu, input logic [3:0] op,
                            input logic rs, input int l, output word_t d, output logic exc);
    word_t base;
    exc = 1'b0;
    case (fu)
      vector_types_pkg::FU_ARITH: d = arith_model(op, stage_a[l], stage_b[l]);
      vector_types_pkg::FU_RED: begin
        base   = rs ? reduction_identity(op) : acc[l];
        d      = arith_model(op, base, stage_a[l]);  // running ADD, MAX or MIN
        acc[l] = d;
      end
      vector_types_pkg::FU_MUL: d = mul_model(op[1:0], stage_a[l], stage_b[l]);
      vector_types_pkg::FU_DIV: div_model(op[1:0], stage_a[l], stage_b[l], d, exc);
      default:                  d = mask_model(op[2:0], stage_a[l], stage_b[l]);
    endcase
  endtask

  // expected outputs for the coming posedge, stable while sampled
  always @(negedge CLK) begin
    int n;
    n             = cyc + 1;
    exp_busy      = (n > div_issue) && (n <= div_issue + lane_config_pkg::DIV_LATENCY);
    exp_next_busy = 1'b0;
    foreach (exp_q[j]) begin
      if (exp_q[j].mul && exp_q[j].due == n + 1) begin
        exp_next_busy = 1'b1;  // mul retires one cycle later
      end
    end
    exp_valid = 1'b0;
    if (exp_q.size() != 0 && exp_q[0].due == n) begin
      exp_valid = 1'b1;
      exp_data  = exp_q[0].data;
      exp_exc   = exp_q[0].exc;
      void'(exp_q.pop_front());
      results_seen++;
    end
  end

  task automatic report_mismatch(input string name, input word_t expected, input word_t actual);
    check_errors++;
    $display("ERROR %0t %s expected %h actual %h", $time, name, expected, actual);
  endtask

  for (genvar g = 0; g < lane_config_pkg::LANES; g++) begin : g_check
    a_valid: assert property (@(posedge CLK) disable iff (!nRST) results[g].valid == exp_valid)
      else report_mismatch($sformatf("results[%0d].valid", g), word_t'(exp_valid),
                           word_t'($sampled(results[g].valid)));
    a_data: assert property (@(posedge CLK) disable iff (!nRST)
      exp_valid |-> results[g].data == exp_data[g])
      else report_mismatch($sformatf("results[%0d].data", g), exp_data[g],
                           $sampled(results[g].data));
    a_exc: assert property (@(posedge CLK) disable iff (!nRST)
      exp_valid |-> results[g].exception == exp_exc[g])
      else report_mismatch($sformatf("results[%0d].exception", g), word_t'(exp_exc[g]),
                           word_t'($sampled(results[g].exception)));
    a_busy: assert property (@(posedge CLK) disable iff (!nRST) busy[g] == exp_busy)
      else report_mismatch($sformatf("busy[%0d]", g), word_t'(exp_busy),
                           word_t'($sampled(busy[g])));
    a_next_busy: assert property (@(posedge CLK) disable iff (!nRST)
      next_busy[g] == exp_next_busy)
      else report_mismatch($sformatf("next_busy[%0d]", g), word_t'(exp_next_busy),
                           word_t'($sampled(next_busy[g])));
  end

  // drives one issue at a falling edge, model entry goes in the queue
  task automatic issue_op(input vector_types_pkg::fu_type_t fu, input logic [3:0] op,
                          input logic rs);
    expect_t e;
    word_t   d;
    logic    x;
    int      lat;
    lat = 1;
    if (fu == vector_types_pkg::FU_MUL) lat = lane_config_pkg::MUL_LATENCY;
    if (fu == vector_types_pkg::FU_DIV) lat = lane_config_pkg::DIV_LATENCY;
    e.due = cyc + 1 + lat;  // cyc + 1 takes the issue
    e.mul = (fu == vector_types_pkg::FU_MUL);
    for (int l = 0; l < lane_config_pkg::LANES; l++) begin
      model_lane(fu, op, rs, l, d, x);
      e.data[l]     = d;
      e.exc[l]      = x;
      operands[l].a = stage_a[l];
      operands[l].b = stage_b[l];
    end
    if (fu == vector_types_pkg::FU_DIV) div_issue = cyc + 1;
    issue.valid     = 1'b1;
    issue.fu        = fu;
    issue.op        = op;
    issue.red_start = rs;
    exp_q.push_back(e);
    @(negedge CLK);
    issue.valid = 1'b0;  // strobe, one cycle
  endtask

  task automatic fill_random();
    for (int l = 0; l < lane_config_pkg::LANES; l++) begin
      random_operand(stage_a[l]);
      random_operand(stage_b[l]);
    end
  endtask

  task automatic fill_single_bit();
    word_t pick;
    for (int l = 0; l < lane_config_pkg::LANES; l++) begin
      take_bits(5, pick);
      stage_a[l] = word_t'(1) << pick[4:0];  // random bit position per lane
      random_operand(stage_b[l]);
    end
  endtask

  // issue rule, busy low and next_busy low
  task automatic wait_idle(input int limit);
    int n;
    n = 0;
    while ((busy != '0 || next_busy != '0) && n < limit) begin
      @(negedge CLK);
      n++;
    end
    if (busy != '0 || next_busy != '0) begin
      timeout_errors++;
      $display("timeout at %0t, lanes still busy after %0d cycles", $time, limit);
    end
  endtask

  task automatic wait_results(input int limit);
    int n;
    n = 0;
    do begin
      @(posedge CLK);  // queue only moves on falling edges
      n++;
    end while (exp_q.size() != 0 && n < limit);
    if (exp_q.size() != 0) begin
      timeout_errors++;
      $display("timeout at %0t, %0d results never arrived", $time, exp_q.size());
      exp_q.delete();
    end
    @(negedge CLK);
  endtask

  task automatic arith_sweep();
    wait_idle(50);
    for (int k = 0; k <= int'(vector_types_pkg::MAXU); k++) begin
      for (int n = 0; n < 4; n++) begin
        fill_random();
        issue_op(vector_types_pkg::FU_ARITH, 4'(k), 1'b0);  // back to back
      end
    end
    wait_results(10);
  endtask

  task automatic reduction_sequences();
    logic [3:0] red_ops [3];
    red_ops = '{vector_types_pkg::ADD, vector_types_pkg::MAX, vector_types_pkg::MIN};
    wait_idle(50);
    fill_random();
    issue_op(vector_types_pkg::FU_RED, vector_types_pkg::ADD, 1'b0);  // acc zero from reset
    foreach (red_ops[r]) begin
      for (int n = 0; n < 6; n++) begin
        fill_random();
        issue_op(vector_types_pkg::FU_RED, red_ops[r], n == 0);  // restart on first only
      end
    end
    wait_results(10);
  endtask

  task automatic mul_burst();
    wait_idle(50);
    for (int n = 0; n < 3; n++) begin
      for (int k = 0; k < 4; k++) begin
        fill_random();
        issue_op(vector_types_pkg::FU_MUL, 4'(k), 1'b0);  // three in flight
      end
    end
    wait_results(10);
  endtask

  task automatic div_cases();
    for (int k = 0; k < 4; k++) begin
      for (int n = 0; n < 5; n++) begin
        fill_random();
        for (int l = 0; l < lane_config_pkg::LANES; l++) begin
          if (n == 3 && l % 2 == 0) stage_b[l] = '0;  // even lanes divide by zero
          if (n == 4) begin
            stage_a[l] = most_negative();  // overflow
            stage_b[l] = '1;
          end
        end
        wait_idle(lane_config_pkg::DIV_LATENCY + 8);
        issue_op(vector_types_pkg::FU_DIV, 4'(k), 1'b0);
      end
    end
    wait_results(lane_config_pkg::DIV_LATENCY + 8);
  endtask

  task automatic mask_cases();
    wait_idle(50);
    for (int k = 0; k <= int'(vector_types_pkg::MFIRST); k++) begin
      for (int n = 0; n < 4; n++) begin
        fill_random();
        issue_op(vector_types_pkg::FU_MASK, 4'(k), 1'b0);
      end
    end
    for (int k = int'(vector_types_pkg::MPOPC); k <= int'(vector_types_pkg::MFIRST); k++) begin
      fill_random();
      for (int l = 0; l < lane_config_pkg::LANES; l++) stage_a[l] = '0;
      issue_op(vector_types_pkg::FU_MASK, 4'(k), 1'b0);
      fill_single_bit();
      issue_op(vector_types_pkg::FU_MASK, 4'(k), 1'b0);
    end
    wait_results(10);
  endtask

  initial begin
    nRST  = 1'b0;  // reset from time zero
    issue = '0;
    for (int l = 0; l < lane_config_pkg::LANES; l++) begin
      operands[l] = '0;
      stage_a[l]  = '0;
      stage_b[l]  = '0;
      acc[l]      = '0;
    end
    repeat (8) @(negedge CLK);
    nRST = 1'b1;
    repeat (6) @(negedge CLK);  // idle, outputs stay low
    arith_sweep();
    reduction_sequences();
    mul_burst();
    div_cases();
    mask_cases();
    repeat (4) @(negedge CLK);
    $display("%0d check errors, %0d timeouts, %0d results checked",
             check_errors, timeout_errors, results_seen);
    if (check_errors == 0 && timeout_errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
source/lane_config_pkg.sv
source/vector_types_pkg.sv
source/arithmetic_unit.sv
source/multiply_unit.sv
source/divide_unit.sv
source/mask_unit.sv
source/vector_lane.sv
source/vector_lanes.sv
bench/vector_lanes_tb.sv

//--- run.sh
#!/bin/sh
# builds the slice and its testbench with Verilator, runs it, passes only on the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -j 0 --top-module vector_lanes_tb \
  -Mdir obj_dir -f all.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vvector_lanes_tb)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx 'TESTBENCH PASSED'; then
  exit 0
fi
exit 1
